/* Bender.yml */
package:
  name: fpu_share

export_include_dirs:
  - hw

sources:
  - files:
      - hw/fpu_share_pkg.sv
      - hw/fpu_share_ops.sv
      - hw/fpu_share_unit.sv
      - hw/fpu_share_arbiter.sv
      - hw/fpu_share_resp_router.sv
      - hw/fpu_share_cluster.sv
  - target: test
    files:
      - dv/fpu_share_clk_gen.sv
      - dv/fpu_share_props.sv
      - dv/fpu_share_tb.sv

/* dv/fpu_share_clk_gen.sv */
// Clock and reset source for the testbench
// Free-running clock, reset held low for a few cycles

`timescale 1ns/1ps

module fpu_share_clk_gen #(
   parameter int unsigned PERIOD_NS  = 40,
   parameter int unsigned RST_CYCLES = 5
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial
   begin
      arst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      arst_n_o <= 1'b1;
   end

endmodule

/* dv/fpu_share_props.sv */
// Concurrent checks on the core-side handshakes of the cluster
// Grant only with request, responses held under back-pressure,
// one grant per response

`timescale 1ns/1ps

`include "fpu_share_defines.svh"

module fpu_share_props (
   input  logic                                         clk,
   input  logic                                         arst_n_i,
   input  logic [`FPU_NB_CORES-1:0]                     req_i,
   input  logic [`FPU_NB_CORES-1:0]                     gnt_i,
   input  logic [`FPU_NB_CORES-1:0]                     rvalid_i,
   input  logic [`FPU_NB_CORES-1:0]                     rready_i,
   input  fpu_share_pkg::fpu_rsp_t [`FPU_NB_CORES-1:0]  rsp_i
);

   logic [`FPU_NB_CORES-1:0] pending_q;
   int                       fail_cnt = 0;

   // Cores granted and not yet answered
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         pending_q <= '0;
      else
         pending_q <= (pending_q & ~(rvalid_i & rready_i)) | (req_i & gnt_i);
   end

   for (genvar c = 0; c < `FPU_NB_CORES; c++)
   begin : g_core
      a_gnt_needs_req : assert property (@(posedge clk) disable iff (!arst_n_i)
         gnt_i[c] |-> req_i[c])
         else
         begin
            $error("Core %0d granted without a request", c);
            fail_cnt++;
         end

      a_rsp_held : assert property (@(posedge clk) disable iff (!arst_n_i)
         (rvalid_i[c] && !rready_i[c]) |=> (rvalid_i[c] && $stable(rsp_i[c])))
         else
         begin
            $error("Core %0d response dropped or changed while held", c);
            fail_cnt++;
         end

      a_one_grant : assert property (@(posedge clk) disable iff (!arst_n_i)
         gnt_i[c] |-> !pending_q[c])
         else
         begin
            $error("Core %0d granted twice without a response", c);
            fail_cnt++;
         end
   end

endmodule

/* dv/fpu_share_stim.txt */
# core op opa opb result flags, all hex; flags are NV DZ OF UF NX with NV in bit 4
# op codes: 0 SGNJ 1 SGNJN 2 SGNJX 3 MIN 4 MAX 5 EQ 6 LT 7 LE
0 0 3F800000 C0000000 BF800000 00
1 1 3F800000 C0000000 3F800000 00
2 2 BF800000 C0000000 3F800000 00
3 0 80000000 00000000 00000000 00
0 1 00000000 00000000 80000000 00
1 2 80000000 80000000 00000000 00
2 3 80000000 00000000 80000000 00
3 4 80000000 00000000 00000000 00
0 3 7FC00000 3F800000 3F800000 00
1 4 7F800001 40000000 40000000 10
2 3 7FC00000 7F800001 7FC00000 10
3 3 C0000000 BF800000 C0000000 00
0 4 3F800000 40000000 40000000 00
1 5 7FC00000 7FC00000 00000000 00
2 5 7F800001 3F800000 00000000 10
3 6 7FC00000 3F800000 00000000 10
0 7 3F800000 3F800000 00000001 00
1 6 80000000 00000000 00000000 00
2 7 80000000 00000000 00000001 00
3 5 00000000 80000000 00000001 00
0 6 BF800000 3F800000 00000001 00
1 7 40000000 3F800000 00000000 00

/* dv/fpu_share_tb.sv */
// Testbench top for the shared FP cluster
// Loads the stim file, drives four cores, checks results and flags
// Random rready back-pressure, watchdog and bound handshake checks

`timescale 1ns/1ps

`include "fpu_share_defines.svh"

module fpu_share_tb;

   // One stim line: issuing core, request and expected response
   typedef struct packed {
      logic [`FPU_ID_WIDTH-1:0] core;
      fpu_share_pkg::fpu_req_t  req;
      fpu_share_pkg::fpu_rsp_t  exp;
   } stim_t;

   logic                                         clk;
   logic                                         arst_n;
   logic [`FPU_NB_CORES-1:0]                     core_req;
   fpu_share_pkg::fpu_req_t [`FPU_NB_CORES-1:0]  core_req_data;
   logic [`FPU_NB_CORES-1:0]                     core_gnt;
   logic [`FPU_NB_CORES-1:0]                     core_rvalid;
   logic [`FPU_NB_CORES-1:0]                     core_rready;
   fpu_share_pkg::fpu_rsp_t [`FPU_NB_CORES-1:0]  core_rsp;

   stim_t                    stim_q[$];
   logic [`FPU_NB_CORES-1:0] core_done;
   logic                     run_start;

   fpu_share_clk_gen i_clk_gen (
      .clk_o    ( clk    ),
      .arst_n_o ( arst_n )
   );

   fpu_share_cluster dut0 (
      .clk             ( clk           ),
      .arst_n_i        ( arst_n        ),
      .core_req_i      ( core_req      ),
      .core_req_data_i ( core_req_data ),
      .core_gnt_o      ( core_gnt      ),
      .core_rvalid_o   ( core_rvalid   ),
      .core_rready_i   ( core_rready   ),
      .core_rsp_o      ( core_rsp      )
   );

   bind fpu_share_cluster fpu_share_props i_props (
      .clk      ( clk           ),
      .arst_n_i ( arst_n_i      ),
      .req_i    ( core_req_i    ),
      .gnt_i    ( core_gnt_o    ),
      .rvalid_i ( core_rvalid_o ),
      .rready_i ( core_rready_i ),
      .rsp_i    ( core_rsp_o    )
   );

   ////////////////////
   // Helpers

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "Mismatch on %s", what);
      end
   endtask

   // Comment lines start with #, data lines hold six hex fields
   task automatic load_stimulus();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f_core, f_op, f_opa, f_opb, f_data, f_flags;
      stim_t       rec;
      fd = $fopen("dv/fpu_share_stim.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the stimulus file dv/fpu_share_stim.txt");
         $display("Simulation finished: FAIL");
         $fatal(1, "Missing stimulus");
      end
      while ($fgets(line, fd))
      begin
         n = 0;
         if (line.len() > 1 && line.getc(0) != "#")
            n = $sscanf(line, "%h %h %h %h %h %h", f_core, f_op, f_opa, f_opb,
                        f_data, f_flags);
         if (n == 6)
         begin
            rec.core       = f_core[`FPU_ID_WIDTH-1:0];
            rec.req.op     = fpu_share_pkg::fpu_op_e'(f_op[`FPU_OP_WIDTH-1:0]);
            rec.req.opa    = f_opa;
            rec.req.opb    = f_opb;
            rec.exp.data   = f_data;
            rec.exp.flags  = f_flags[`FPU_FLAGS_WIDTH-1:0];
            stim_q.push_back(rec);
         end
      end
      $fclose(fd);
      if (stim_q.size() == 0)
      begin
         $display("The stimulus file holds no requests");
         $display("Simulation finished: FAIL");
         $fatal(1, "Empty stimulus");
      end
   endtask

   ////////////////////
   // Per-core drivers

   // Each core walks its own lines in file order
   for (genvar c = 0; c < `FPU_NB_CORES; c++)
   begin : g_core
      initial
      begin : drive
         stim_t rec;
         wait (run_start);
         for (int i = 0; i < stim_q.size(); i++)
         begin
            rec = stim_q[i];
            if (rec.core == c)
            begin
               @(posedge clk);
               core_req[c]      <= 1'b1;
               core_req_data[c] <= rec.req;
               @(posedge clk);
               while (!core_gnt[c])
               begin
                  check_value($sformatf("core %0d rvalid while idle", c),
                              core_rvalid[c], 32'd0);
                  @(posedge clk);
               end
               core_req[c] <= 1'b0;
               @(posedge clk);
               while (!(core_rvalid[c] && core_rready[c]))
                  @(posedge clk);
               check_value($sformatf("core %0d line %0d data", c, i),
                           core_rsp[c].data, rec.exp.data);
               check_value($sformatf("core %0d line %0d flags", c, i),
                           core_rsp[c].flags, rec.exp.flags);
            end
         end
         core_done[c] = 1'b1;
      end
   end

   ////////////////////
   // Main sequence

   initial
   begin : main
      void'($urandom(95503));
      core_req      = '0;
      core_req_data = '0;
      core_rready   = '0;
      core_done     = '0;
      run_start     = 1'b0;
      load_stimulus();
      wait (arst_n);
      // Quiet cluster with no requests
      repeat (3)
      begin
         @(posedge clk);
         check_value("gnt before any request", core_gnt, 32'd0);
         check_value("rvalid before any request", core_rvalid, 32'd0);
      end
      run_start = 1'b1;
      // Random back-pressure until every core is through
      while (core_done != '1)
      begin
         @(posedge clk);
         core_rready <= `FPU_NB_CORES'($urandom);
      end
      @(posedge clk);
      check_value("rvalid after the last response", core_rvalid, 32'd0);
      // Assertions of the last edge complete first
      @(negedge clk);
      $display("Simulation finished: PASS");
      $finish;
   end

   initial
   begin : assert_watch
      wait (dut0.i_props.fail_cnt != 0);
      $display("A handshake assertion failed at %0t ns", $time);
      $display("Simulation finished: FAIL");
      $fatal(1, "Assertion failure");
   end

   initial
   begin : watchdog
      wait (run_start);
      repeat (60 * stim_q.size()) @(posedge clk);
      $display("Watchdog expired at %0t ns with responses still missing", $time);
      $display("Simulation finished: FAIL");
      $fatal(1, "Timeout");
   end

endmodule

/* fpu_share.f */
+incdir+hw
hw/fpu_share_pkg.sv
hw/fpu_share_ops.sv
hw/fpu_share_unit.sv
hw/fpu_share_arbiter.sv
hw/fpu_share_resp_router.sv
hw/fpu_share_cluster.sv
dv/fpu_share_clk_gen.sv
dv/fpu_share_props.sv
dv/fpu_share_tb.sv

/* hw/fpu_share_arbiter.sv */
// Round-robin allocation of shared FP units to cores
// Per-core busy marks enforce one outstanding request per core
// Builds the issue record by tagging each request with its core ID

`timescale 1ns/1ps

`include "fpu_share_defines.svh"

module fpu_share_arbiter (
   input  logic                                          clk,
   input  logic                                          arst_n_i,

   input  logic [`FPU_NB_CORES-1:0]                      core_req_i,
   input  fpu_share_pkg::fpu_req_t [`FPU_NB_CORES-1:0]   core_req_data_i,
   output logic [`FPU_NB_CORES-1:0]                      core_gnt_o,
   input  logic [`FPU_NB_CORES-1:0]                      rsp_done_i,

   output logic [`FPU_NB_UNITS-1:0]                      unit_req_o,
   output fpu_share_pkg::fpu_issue_t [`FPU_NB_UNITS-1:0] unit_issue_o,
   input  logic [`FPU_NB_UNITS-1:0]                      unit_gnt_i
);

   localparam int unsigned ID_W = `FPU_ID_WIDTH;

   logic [ID_W-1:0]                          ptr_q;
   logic [`FPU_NB_CORES-1:0]                 busy_q;
   logic [`FPU_NB_CORES-1:0]                 eligible;
   logic [`FPU_NB_UNITS-1:0][ID_W-1:0]       unit_id;
   logic [ID_W-1:0]                          scan_idx;
   logic [ID_W-1:0]                          last_core;

   assign eligible = core_req_i & ~busy_q;

   ////////////////////
   // Matching

   // Free units take cores in index order, each scan starting at the pointer
   always_comb
   begin
      core_gnt_o = '0;
      unit_req_o = '0;
      unit_id    = '0;
      scan_idx   = '0;
      last_core  = ptr_q;
      for (int u = 0; u < `FPU_NB_UNITS; u++)
      begin
         for (int k = 0; k < `FPU_NB_CORES; k++)
         begin
            scan_idx = ID_W'((int'(ptr_q) + k) % `FPU_NB_CORES);
            if (unit_gnt_i[u] && !unit_req_o[u] && eligible[scan_idx] &&
                !core_gnt_o[scan_idx])
            begin
               unit_req_o[u]        = 1'b1;
               unit_id[u]           = scan_idx;
               core_gnt_o[scan_idx] = 1'b1;
               last_core            = scan_idx;
            end
         end
      end
   end

   always_comb
   begin
      for (int u = 0; u < `FPU_NB_UNITS; u++)
      begin
         unit_issue_o[u].id  = unit_id[u];
         unit_issue_o[u].req = core_req_data_i[unit_id[u]];
      end
   end

   ////////////////////
   // Pointer and busy marks

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ptr_q  <= '0;
         busy_q <= '0;
      end
      else
      begin
         busy_q <= (busy_q & ~rsp_done_i) | core_gnt_o;
         // Skip past the last core served this cycle
         if (|core_gnt_o)
         begin
            ptr_q <= (last_core == ID_W'(`FPU_NB_CORES - 1)) ? '0 : last_core + 1'b1;
         end
      end
   end

endmodule

/* hw/fpu_share_cluster.sv */
// Shared FP cluster top level
// Arbiter, shared FP units and response router

`timescale 1ns/1ps

`include "fpu_share_defines.svh"

module fpu_share_cluster (
   input  logic                                         clk,
   input  logic                                         arst_n_i,

   input  logic [`FPU_NB_CORES-1:0]                     core_req_i,
   input  fpu_share_pkg::fpu_req_t [`FPU_NB_CORES-1:0]  core_req_data_i,
   output logic [`FPU_NB_CORES-1:0]                     core_gnt_o,

   output logic [`FPU_NB_CORES-1:0]                     core_rvalid_o,
   input  logic [`FPU_NB_CORES-1:0]                     core_rready_i,
   output fpu_share_pkg::fpu_rsp_t [`FPU_NB_CORES-1:0]  core_rsp_o
);

   logic [`FPU_NB_UNITS-1:0]                      unit_req, unit_gnt;
   fpu_share_pkg::fpu_issue_t [`FPU_NB_UNITS-1:0] unit_issue;
   logic [`FPU_NB_UNITS-1:0]                      unit_rvalid, unit_rready;
   fpu_share_pkg::fpu_rsp_t [`FPU_NB_UNITS-1:0]   unit_rsp;
   logic [`FPU_NB_UNITS-1:0][`FPU_ID_WIDTH-1:0]   unit_rid;
   logic [`FPU_NB_CORES-1:0]                      rsp_done;

   fpu_share_arbiter i_arbiter (
      .clk             ( clk             ),
      .arst_n_i        ( arst_n_i        ),
      .core_req_i      ( core_req_i      ),
      .core_req_data_i ( core_req_data_i ),
      .core_gnt_o      ( core_gnt_o      ),
      .rsp_done_i      ( rsp_done        ),
      .unit_req_o      ( unit_req        ),
      .unit_issue_o    ( unit_issue      ),
      .unit_gnt_i      ( unit_gnt        )
   );

   for (genvar u = 0; u < `FPU_NB_UNITS; u++)
   begin : g_unit
      fpu_share_unit i_unit (
         .clk         ( clk            ),
         .arst_n_i    ( arst_n_i       ),
         .issue_req_i ( unit_req[u]    ),
         .issue_i     ( unit_issue[u]  ),
         .issue_gnt_o ( unit_gnt[u]    ),
         .rvalid_o    ( unit_rvalid[u] ),
         .rsp_o       ( unit_rsp[u]    ),
         .rid_o       ( unit_rid[u]    ),
         .rready_i    ( unit_rready[u] )
      );
   end

   fpu_share_resp_router i_resp_router (
      .unit_rvalid_i ( unit_rvalid   ),
      .unit_rsp_i    ( unit_rsp      ),
      .unit_rid_i    ( unit_rid      ),
      .unit_rready_o ( unit_rready   ),
      .core_rvalid_o ( core_rvalid_o ),
      .core_rsp_o    ( core_rsp_o    ),
      .core_rready_i ( core_rready_i ),
      .rsp_done_o    ( rsp_done      )
   );

endmodule

/* hw/fpu_share_defines.svh */
// Cluster sizing for the shared FP cluster
// Core and unit counts, operand, opcode, flag and ID widths
// Pipeline depth of one shared unit

`ifndef FPU_SHARE_DEFINES_SVH
`define FPU_SHARE_DEFINES_SVH

////////////////////
// Cluster sizing

`define FPU_NB_CORES    4
`define FPU_NB_UNITS    2

////////////////////
// Field widths

`define FPU_DATA_WIDTH  32
`define FPU_OP_WIDTH    3
// Flag order is NV DZ OF UF NX, NV in the MSB
`define FPU_FLAGS_WIDTH 5
`define FPU_ID_WIDTH    2

// Unit pipeline depth, issue to response
`define FPU_UNIT_LAT    2

`endif

/* hw/fpu_share_ops.sv */
// FP32 operations without rounding
// Sign injection, min/max with NaN handling, EQ/LT/LE compares
// Invalid flag for NaN operands

`timescale 1ns/1ps

`include "fpu_share_defines.svh"

module fpu_share_ops (
   input  fpu_share_pkg::fpu_op_e  op_i,
   input  fpu_share_pkg::fp_word_u opa_i,
   input  fpu_share_pkg::fp_word_u opb_i,
   output fpu_share_pkg::fpu_rsp_t rsp_o
);

   localparam logic [`FPU_DATA_WIDTH-1:0] CANON_NAN = 32'h7FC0_0000;

   logic                    a_nan, b_nan, a_snan, b_snan, any_nan;
   logic                    both_zero, a_lt_b, lt_ieee, eq_ieee, nv;
   fpu_share_pkg::fp_word_u res;

   assign a_nan   = (&opa_i.fields.exponent) && (|opa_i.fields.mantissa);
   assign b_nan   = (&opb_i.fields.exponent) && (|opb_i.fields.mantissa);
   // Quiet bit is the mantissa MSB
   assign a_snan  = a_nan && !opa_i.fields.mantissa[22];
   assign b_snan  = b_nan && !opb_i.fields.mantissa[22];
   assign any_nan = a_nan || b_nan;

   // Total order on non-NaN values, -0 below +0
   assign a_lt_b = (opa_i.fields.sign != opb_i.fields.sign) ? opa_i.fields.sign :
                   opa_i.fields.sign ? (opa_i.raw[30:0] > opb_i.raw[30:0]) :
                                       (opa_i.raw[30:0] < opb_i.raw[30:0]);

   // Compares treat the two zeros as equal
   assign both_zero = (opa_i.raw[30:0] == '0) && (opb_i.raw[30:0] == '0);
   assign lt_ieee   = a_lt_b && !both_zero;
   assign eq_ieee   = (opa_i.raw == opb_i.raw) || both_zero;

   always_comb
   begin
      res = opa_i;
      nv  = 1'b0;
      case (op_i)
         fpu_share_pkg::SGNJ:  res.fields.sign = opb_i.fields.sign;
         fpu_share_pkg::SGNJN: res.fields.sign = ~opb_i.fields.sign;
         fpu_share_pkg::SGNJX: res.fields.sign = opa_i.fields.sign ^ opb_i.fields.sign;
         fpu_share_pkg::MIN, fpu_share_pkg::MAX:
         begin
            nv = a_snan || b_snan;
            if (a_nan && b_nan)
               res.raw = CANON_NAN;
            else if (a_nan)
               res = opb_i;
            else if (b_nan)
               res = opa_i;
            else if (op_i == fpu_share_pkg::MIN)
               res = a_lt_b ? opa_i : opb_i;
            else
               res = a_lt_b ? opb_i : opa_i;
         end
         fpu_share_pkg::EQ:
         begin
            nv      = a_snan || b_snan;
            res.raw = `FPU_DATA_WIDTH'(!any_nan && eq_ieee);
         end
         fpu_share_pkg::LT:
         begin
            nv      = any_nan;
            res.raw = `FPU_DATA_WIDTH'(!any_nan && lt_ieee);
         end
         fpu_share_pkg::LE:
         begin
            nv      = any_nan;
            res.raw = `FPU_DATA_WIDTH'(!any_nan && (lt_ieee || eq_ieee));
         end
         default: res.raw = '0;
      endcase
   end

   assign rsp_o.data  = res.raw;
   assign rsp_o.flags = {nv, {(`FPU_FLAGS_WIDTH - 1){1'b0}}};

endmodule

/* hw/fpu_share_pkg.sv */
// Types shared by the FP cluster
// Operation codes, FP32 operand views, request, issue and response records

`include "fpu_share_defines.svh"

package fpu_share_pkg;

   // Operations that need no rounding
   typedef enum logic [`FPU_OP_WIDTH-1:0] {
      SGNJ  = 3'd0,
      SGNJN = 3'd1,
      SGNJX = 3'd2,
      MIN   = 3'd3,
      MAX   = 3'd4,
      EQ    = 3'd5,
      LT    = 3'd6,
      LE    = 3'd7
   } fpu_op_e;

   // Single precision fields
   typedef struct packed {
      logic        sign;
      logic [7:0]  exponent;
      logic [22:0] mantissa;
   } fp32_t;

   // Operand seen either as a raw word or as fields
   typedef union packed {
      logic [`FPU_DATA_WIDTH-1:0] raw;
      fp32_t                      fields;
   } fp_word_u;

   typedef struct packed {
      fpu_op_e  op;
      fp_word_u opa;
      fp_word_u opb;
   } fpu_req_t;

   // Request plus the ID of the core it came from
   typedef struct packed {
      logic [`FPU_ID_WIDTH-1:0] id;
      fpu_req_t                 req;
   } fpu_issue_t;

   typedef struct packed {
      logic [`FPU_DATA_WIDTH-1:0]  data;
      logic [`FPU_FLAGS_WIDTH-1:0] flags;
   } fpu_rsp_t;

endpackage

/* hw/fpu_share_resp_router.sv */
// Response steering from shared units back to cores
// Returns the target core's rready and flags completed handshakes

`timescale 1ns/1ps

`include "fpu_share_defines.svh"

module fpu_share_resp_router (
   input  logic [`FPU_NB_UNITS-1:0]                     unit_rvalid_i,
   input  fpu_share_pkg::fpu_rsp_t [`FPU_NB_UNITS-1:0]  unit_rsp_i,
   input  logic [`FPU_NB_UNITS-1:0][`FPU_ID_WIDTH-1:0]  unit_rid_i,
   output logic [`FPU_NB_UNITS-1:0]                     unit_rready_o,

   output logic [`FPU_NB_CORES-1:0]                     core_rvalid_o,
   output fpu_share_pkg::fpu_rsp_t [`FPU_NB_CORES-1:0]  core_rsp_o,
   input  logic [`FPU_NB_CORES-1:0]                     core_rready_i,

   output logic [`FPU_NB_CORES-1:0]                     rsp_done_o
);

   // One outstanding request per core, so no two units aim at one core
   always_comb
   begin
      core_rvalid_o = '0;
      core_rsp_o    = '0;
      for (int u = 0; u < `FPU_NB_UNITS; u++)
      begin
         unit_rready_o[u] = core_rready_i[unit_rid_i[u]];
         if (unit_rvalid_i[u])
         begin
            core_rvalid_o[unit_rid_i[u]] = 1'b1;
            core_rsp_o[unit_rid_i[u]]    = unit_rsp_i[u];
         end
      end
   end

   ////////////////////
   // Completion

   // Frees the core's busy mark in the arbiter
   assign rsp_done_o = core_rvalid_o & core_rready_i;

endmodule

/* hw/fpu_share_unit.sv */
// One shared FP unit
// Stage 1 holds the issued request, stage 2 holds result and core ID
// Output stage waits for rready, stage 1 stalls behind it

`timescale 1ns/1ps

`include "fpu_share_defines.svh"

module fpu_share_unit (
   input  logic                       clk,
   input  logic                       arst_n_i,

   input  logic                       issue_req_i,
   input  fpu_share_pkg::fpu_issue_t  issue_i,
   output logic                       issue_gnt_o,

   output logic                       rvalid_o,
   output fpu_share_pkg::fpu_rsp_t    rsp_o,
   output logic [`FPU_ID_WIDTH-1:0]   rid_o,
   input  logic                       rready_i
);

   localparam int unsigned NB_STAGES = `FPU_UNIT_LAT;

   logic [NB_STAGES-1:0]        valid_q;
   fpu_share_pkg::fpu_issue_t   s1_q;
   fpu_share_pkg::fpu_rsp_t     ops_rsp;
   fpu_share_pkg::fpu_rsp_t     s2_rsp_q;
   logic [`FPU_ID_WIDTH-1:0]    s2_id_q;
   logic                        s2_free, s1_load, s2_load;

   assign s2_free     = !valid_q[1] || rready_i;
   // Only an empty input stage accepts
   assign issue_gnt_o = !valid_q[0];
   assign s1_load     = issue_req_i && issue_gnt_o;
   assign s2_load     = valid_q[0] && s2_free;

   fpu_share_ops i_ops (
      .op_i  ( s1_q.req.op  ),
      .opa_i ( s1_q.req.opa ),
      .opb_i ( s1_q.req.opb ),
      .rsp_o ( ops_rsp      )
   );

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         valid_q <= '0;
      end
      else
      begin
         valid_q[0] <= s1_load || (valid_q[0] && !s2_free);
         valid_q[1] <= s2_load || (valid_q[1] && !rready_i);
      end
   end

   always_ff @(posedge clk)
   begin
      if (s1_load)
         s1_q <= issue_i;
      if (s2_load)
      begin
         s2_rsp_q <= ops_rsp;
         s2_id_q  <= s1_q.id;
      end
   end

   assign rvalid_o = valid_q[1];
   assign rsp_o    = s2_rsp_q;
   assign rid_o    = s2_id_q;

endmodule
